// ==== src/pong_pkg.sv ====
package pong_pkg;

    // Screen coordinate, covers 0..1023
    typedef logic [9:0] coord_t;

    // 4 bits per colour channel
    typedef logic [11:0] rgb_t;

    // 100 MHz / 60, fits 21 bits
    localparam int unsigned FRAME_DIV = 1_666_666;

    // Alternative tick fires once per frame, just past the visible area
    localparam coord_t SCAN_TICK_X = 10'd0;
    localparam coord_t SCAN_TICK_Y = 10'd481;

    // Left wall
    localparam coord_t WALL_X_L = 10'd32;
    localparam coord_t WALL_X_R = 10'd35;

    // Horizontal walls
    localparam coord_t TOP_WALL_Y   = 10'd5;    // Last row of top wall
    localparam coord_t BOT_WALL_Y   = 10'd475;  // First row of bottom wall
    localparam coord_t SCREEN_X_MAX = 10'd640;  // Right end of both walls
    localparam coord_t SCREEN_Y_MAX = 10'd480;  // Last row of bottom wall

    // Paddle
    localparam coord_t BAR_X_L    = 10'd600;
    localparam coord_t BAR_X_R    = 10'd603;
    localparam coord_t BAR_Y_SIZE = 10'd72;
    localparam coord_t BAR_V      = 10'd4;      // Pixels per tick

    // Ball box is square
    localparam coord_t BALL_SIZE = 10'd16;

    // Ball deltas, two's complement
    localparam logic signed [9:0] BALL_V_P = 10'sd1;
    localparam logic signed [9:0] BALL_V_N = -10'sd1;

    // Object colours
    localparam rgb_t WALL_RGB  = 12'h00F;
    localparam rgb_t BAR_RGB   = 12'h0F0;
    localparam rgb_t BALL_RGB  = 12'hC0F;
    localparam rgb_t BG_RGB    = 12'h000;
    localparam rgb_t BLANK_RGB = 12'hFFF;       // Shown outside active video

endpackage

// ==== src/frame_tick_gen.sv ====
`timescale 1ns/1ns

module frame_tick_gen #(
    parameter int unsigned TICK_DIV = pong_pkg::FRAME_DIV
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             sw,          // 0 = divider, 1 = scan position
    input  pong_pkg::coord_t pixel_x,
    input  pong_pkg::coord_t pixel_y,
    output logic             frame_tick
);
    import pong_pkg::*;

    // Counter just wide enough for TICK_DIV-1, at least one bit
    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_DIV - 1);

    logic [CNT_W-1:0] div_cnt;
    logic             div_tick;
    logic             scan_tick;

    assign div_tick = (div_cnt == CNT_LAST);  // Terminal count

    // Free running, wraps on its own terminal count whatever sw says
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            div_cnt <= '0;
        else if (div_tick)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    assign scan_tick  = (pixel_x == SCAN_TICK_X) && (pixel_y == SCAN_TICK_Y);
    assign frame_tick = sw ? scan_tick : div_tick;  // Source select

endmodule

// ==== src/paddle_ctrl.sv ====
`timescale 1ns/1ns

module paddle_ctrl (
    input  logic             clk,
    input  logic             reset,
    input  logic             frame_tick,
    input  logic [1:0]       button,      // [0] down, [1] up
    output pong_pkg::coord_t paddle_y     // Top row of paddle
);
    import pong_pkg::*;

    coord_t paddle_bot;
    logic   move_down;
    logic   move_up;

    // Bottom row of paddle
    assign paddle_bot = paddle_y + BAR_Y_SIZE - 10'd1;

    // Keep one full step clear of the bottom wall
    assign move_down = button[0] && (paddle_bot < BOT_WALL_Y - 10'd1 - BAR_V);
    assign move_up   = button[1] && (paddle_y > BAR_V);  // Stop short of row 0

    // Position only changes on a frame tick
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            paddle_y <= '0;
        end else if (frame_tick) begin
            if (move_down)                    // Down wins when both pressed
                paddle_y <= paddle_y + BAR_V;
            else if (move_up)
                paddle_y <= paddle_y - BAR_V;
        end
    end

endmodule

// ==== src/ball_ctrl.sv ====
`timescale 1ns/1ns

module ball_ctrl (
    input  logic             clk,
    input  logic             reset,
    input  logic             frame_tick,
    input  pong_pkg::coord_t paddle_y,
    output pong_pkg::coord_t ball_x,      // Left column of ball box
    output pong_pkg::coord_t ball_y       // Top row of ball box
);
    import pong_pkg::*;

    logic signed [9:0] dx, dy;             // Per-tick steps
    logic signed [9:0] dx_next, dy_next;
    coord_t            ball_right;
    coord_t            ball_bot;
    coord_t            paddle_bot;
    logic              paddle_hit;

    // Ball box edges
    assign ball_right = ball_x + BALL_SIZE - 10'd1;
    assign ball_bot   = ball_y + BALL_SIZE - 10'd1;
    assign paddle_bot = paddle_y + BAR_Y_SIZE - 10'd1;

    // Right edge inside paddle columns and rows overlapping
    assign paddle_hit = (ball_right >= BAR_X_L) && (ball_right <= BAR_X_R) &&
                        (paddle_y <= ball_bot) && (ball_y <= paddle_bot);

    // Bounce rules, first match wins
    always_comb begin
        dx_next = dx;
        dy_next = dy;
        if (ball_y <= TOP_WALL_Y)
            dy_next = BALL_V_P;                      // Top wall
        else if (ball_bot > BOT_WALL_Y - 10'd1)
            dy_next = BALL_V_N;                      // Bottom wall
        else if (ball_x <= WALL_X_R)
            dx_next = BALL_V_P;                      // Left wall
        else if (paddle_hit)
            dx_next = BALL_V_N;                      // Paddle
    end

    // Deltas follow the current position every cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dx <= BALL_V_P;
            dy <= BALL_V_P;
        end else begin
            dx <= dx_next;
            dy <= dy_next;
        end
    end

    // Position advances on a tick only, wraps mod 1024
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ball_x <= '0;
            ball_y <= '0;
        end else if (frame_tick) begin
            ball_x <= ball_x + coord_t'(dx);
            ball_y <= ball_y + coord_t'(dy);
        end
    end

endmodule

// ==== src/pixel_renderer.sv ====
`timescale 1ns/1ns

module pixel_renderer (
    input  logic             video_on,
    input  pong_pkg::coord_t pixel_x,
    input  pong_pkg::coord_t pixel_y,
    input  pong_pkg::coord_t paddle_y,
    input  pong_pkg::coord_t ball_x,
    input  pong_pkg::coord_t ball_y,
    output pong_pkg::rgb_t   rgb
);
    import pong_pkg::*;

    logic       wall_v_on;                 // Left wall
    logic       wall_t_on;                 // Top wall
    logic       wall_b_on;                 // Bottom wall
    logic       wall_on;
    logic       bar_on;
    logic       ball_box_on;
    logic       ball_on;
    coord_t     paddle_bot;
    coord_t     ball_right;
    coord_t     ball_bot;
    logic [2:0] rom_row;
    logic [2:0] rom_col;
    logic [7:0] rom_data;

    // Walls
    assign wall_v_on = (pixel_x >= WALL_X_L) && (pixel_x <= WALL_X_R);
    assign wall_t_on = (pixel_x <= SCREEN_X_MAX) && (pixel_y <= TOP_WALL_Y);
    assign wall_b_on = (pixel_x <= SCREEN_X_MAX) &&
                       (pixel_y >= BOT_WALL_Y) && (pixel_y <= SCREEN_Y_MAX);
    assign wall_on   = wall_v_on || wall_t_on || wall_b_on;

    // Paddle
    assign paddle_bot = paddle_y + BAR_Y_SIZE - 10'd1;
    assign bar_on     = (pixel_x >= BAR_X_L) && (pixel_x <= BAR_X_R) &&
                        (pixel_y >= paddle_y) && (pixel_y <= paddle_bot);

    // Square box around the ball
    assign ball_right  = ball_x + BALL_SIZE - 10'd1;
    assign ball_bot    = ball_y + BALL_SIZE - 10'd1;
    assign ball_box_on = (pixel_x >= ball_x) && (pixel_x <= ball_right) &&
                         (pixel_y >= ball_y) && (pixel_y <= ball_bot);

    // Mask address relative to the box corner, mod 8
    assign rom_row = pixel_y[2:0] - ball_y[2:0];
    assign rom_col = pixel_x[2:0] - ball_x[2:0];

    // Round ball mask, 8x8, repeats over the 16x16 box
    always_comb begin
        case (rom_row)
            3'd0:    rom_data = 8'b0011_1100;
            3'd1:    rom_data = 8'b0111_1110;
            3'd2:    rom_data = 8'b1101_1011;
            3'd3:    rom_data = 8'b1110_0111;
            3'd4:    rom_data = 8'b1110_0111;
            3'd5:    rom_data = 8'b1101_1011;
            3'd6:    rom_data = 8'b0111_1110;
            default: rom_data = 8'b0011_1100;
        endcase
    end

    assign ball_on = ball_box_on && rom_data[rom_col];

    // Fixed priority, blanking first
    always_comb begin
        if (!video_on)
            rgb = BLANK_RGB;
        else if (wall_on)
            rgb = WALL_RGB;
        else if (bar_on)
            rgb = BAR_RGB;
        else if (ball_on)
            rgb = BALL_RGB;
        else
            rgb = BG_RGB;                  // Nothing hit
    end

endmodule

// ==== src/pong_animate.sv ====
`timescale 1ns/1ns

module pong_animate #(
    parameter int unsigned TICK_DIV = pong_pkg::FRAME_DIV  // Divider period in clk cycles
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             sw,          // Tick source select
    input  logic             video_on,
    input  logic [1:0]       button,
    input  pong_pkg::coord_t pixel_x,
    input  pong_pkg::coord_t pixel_y,
    output pong_pkg::rgb_t   rgb
);
    import pong_pkg::*;

    logic   frame_tick;
    coord_t paddle_y;                     // Paddle top row
    coord_t ball_x;                       // Ball box corner
    coord_t ball_y;

    // Once-per-frame pulse
    frame_tick_gen #(
        .TICK_DIV   (TICK_DIV)
    ) u_frame_tick_gen (
        .clk        (clk),
        .reset      (reset),
        .sw         (sw),
        .pixel_x    (pixel_x),
        .pixel_y    (pixel_y),
        .frame_tick (frame_tick)
    );

    // Paddle motion
    paddle_ctrl u_paddle_ctrl (
        .clk        (clk),
        .reset      (reset),
        .frame_tick (frame_tick),
        .button     (button),
        .paddle_y   (paddle_y)
    );

    // Ball motion and bounces
    ball_ctrl u_ball_ctrl (
        .clk        (clk),
        .reset      (reset),
        .frame_tick (frame_tick),
        .paddle_y   (paddle_y),
        .ball_x     (ball_x),
        .ball_y     (ball_y)
    );

    // Same-cycle colour for the current pixel
    pixel_renderer u_pixel_renderer (
        .video_on   (video_on),
        .pixel_x    (pixel_x),
        .pixel_y    (pixel_y),
        .paddle_y   (paddle_y),
        .ball_x     (ball_x),
        .ball_y     (ball_y),
        .rgb        (rgb)
    );

endmodule

// ==== tests/tb_pong_animate.sv ====
`timescale 1ns/1ns

module tb_pong_animate;
    import pong_pkg::*;

    localparam int N_PAD_DOWN = 160;      // Ticks pushing the paddle down
    localparam int N_PAD_UP   = 180;      // Ticks pushing it back up
    localparam int N_BALL     = 1000;     // Scan ticks of ball flight
    // Reset, blanking, geometry, paddle, ball, divider, then a margin
    localparam int CYCLE_LIMIT = 20 + 40 + 60 + (N_PAD_DOWN + N_PAD_UP) * 6
                                 + N_BALL * 4 + 120 + 1000;

    logic       clk;
    logic       reset;
    logic       sw;
    logic       video_on;
    logic [1:0] button;
    coord_t     pixel_x;
    coord_t     pixel_y;
    rgb_t       rgb;

    int          test_errors  = 0;
    int          total_errors = 0;
    int          checks       = 0;
    int          cycles       = 0;
    logic [31:0] lfsr_state   = 32'h664c;

    // Reference model of paddle and ball
    int  py, bx, by, dx, dy;
    bit  saw_bottom, saw_paddle;
    bit  saw_low_stop, saw_top_stop;
    int  rom [8] = '{8'h3C, 8'h7E, 8'hDB, 8'hE7, 8'hE7, 8'hDB, 8'h7E, 8'h3C};

    pong_animate #(.TICK_DIV(16)) u_dut (
        .clk      (clk),
        .reset    (reset),
        .sw       (sw),
        .video_on (video_on),
        .button   (button),
        .pixel_x  (pixel_x),
        .pixel_y  (pixel_y),
        .rgb      (rgb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Blanking must win over everything
    blank_check: assert property (@(negedge clk) disable iff (reset)
        !video_on |-> rgb == 12'hFFF)
        else begin
            $display("** Error [blank_check] expected fff actual %h", rgb);
            test_errors++;
        end

    // Galois LFSR, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] result;
        logic        b;
        result = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b)
                lfsr_state = lfsr_state ^ 32'hD000_0001;
            result = {result[30:0], b};
        end
        return result;
    endfunction

    // Colour the playfield rules give for a pixel, video active
    function automatic logic [11:0] expected_rgb(input int x, input int y);
        int row, col;
        row = (y - by) & 7;
        col = (x - bx) & 7;
        if ((x >= 32 && x <= 35) || (x <= 640 && y <= 5) ||
            (x <= 640 && y >= 475 && y <= 480))
            return 12'h00F;
        if (x >= 600 && x <= 603 && y >= py && y <= py + 71)
            return 12'h0F0;
        if (x >= bx && x <= bx + 15 && y >= by && y <= by + 15 && rom[row][col])
            return 12'hC0F;
        return 12'h000;
    endfunction

    // Deltas from the current position, then one step of motion
    task automatic model_tick(input logic [1:0] b);
        if (by <= 5) begin
            dy = 1;
        end else if (by + 15 > 474) begin
            dy = -1;
            saw_bottom = 1;
        end else if (bx <= 35) begin
            dx = 1;
        end else if (bx + 15 >= 600 && bx + 15 <= 603 && py <= by + 15 && by <= py + 71) begin
            dx = -1;
            saw_paddle = 1;
        end
        bx = (bx + dx) & 1023;
        by = (by + dy) & 1023;
        if (b[0] && py + 71 < 470)       // Down has priority
            py = py + 4;
        else if (b[1] && py > 4)
            py = py - 4;
    endtask

    task automatic check_value(input string name, input logic [11:0] exp, input logic [11:0] got);
        checks++;
        assert (exp == got)
            else begin
                $display("** Error [%s] expected %h actual %h", name, exp, got);
                test_errors++;
            end
    endtask

    task automatic drive_pixel(input int x, input int y);
        @(posedge clk);
        pixel_x <= 10'(x);
        pixel_y <= 10'(y);
    endtask

    // Drive a pixel, compare colour once it settles
    task automatic probe_rgb(input string name, input int x, input int y);
        drive_pixel(x, y);
        @(negedge clk);
        check_value(name, expected_rgb(x, y), rgb);
    endtask

    // One scan tick at (0,481) with buttons held during it
    task automatic frame_step(input logic [1:0] b);
        @(posedge clk);
        pixel_x <= 10'd0;
        pixel_y <= 10'd481;
        button  <= b;
        @(posedge clk);
        pixel_x <= 10'd100;
        pixel_y <= 10'd100;
        model_tick(b);
    endtask

    task automatic reset_dut(input logic sel);
        @(posedge clk);
        reset  <= 1'b1;
        sw     <= sel;
        button <= 2'b00;
        repeat (10) @(posedge clk);
        reset <= 1'b0;                    // Released on this edge
        py = 0;
        bx = 0;
        by = 0;
        dx = 1;
        dy = 1;
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d errors", name, test_errors);
        total_errors += test_errors;
        test_errors = 0;
    endtask

    initial begin
        int x, y, r;
        logic [1:0] b;
        reset    = 1'b1;
        sw       = 1'b1;
        video_on = 1'b1;
        button   = 2'b00;
        pixel_x  = 10'd100;
        pixel_y  = 10'd100;
        saw_bottom   = 0;
        saw_paddle   = 0;
        saw_low_stop = 0;
        saw_top_stop = 0;
        reset_dut(1'b1);

        // Blanking over random pixels, never the scan tick row
        @(posedge clk);
        video_on <= 1'b0;
        for (int i = 0; i < 40; i++) begin
            y = int'(lfsr_bits(9));
            if (y == 481)
                y = 480;
            drive_pixel(int'(lfsr_bits(10)), y);
            @(negedge clk);
            check_value("blanking", 12'hFFF, rgb);
        end
        @(posedge clk);
        video_on <= 1'b1;
        finish_test("blanking");

        // Walls and empty field, ball still hidden at (0,0)
        for (int i = 0; i < 30; i++) begin
            r = int'(lfsr_bits(2)) % 3;
            if (r == 0) begin
                x = 32 + int'(lfsr_bits(2));
                y = int'(lfsr_bits(9));
                if (y > 480)
                    y = y - 32;
            end else begin
                x = int'(lfsr_bits(10)) % 641;
                y = int'(lfsr_bits(3)) % 6;
                if (r == 2)
                    y = y + 475;
            end
            probe_rgb("wall", x, y);
            check_value("wall_colour", 12'h00F, rgb);
        end
        for (int i = 0; i < 30; i++) begin
            x = 40 + int'(lfsr_bits(10)) % 550;
            y = 10 + int'(lfsr_bits(9)) % 460;
            probe_rgb("background", x, y);
            check_value("background_colour", 12'h000, rgb);
        end
        finish_test("static_geometry");

        // Paddle stepping, mostly down then mostly up, hitting both stops
        for (int i = 0; i < N_PAD_DOWN + N_PAD_UP; i++) begin
            if (i < N_PAD_DOWN)
                b = {lfsr_bits(1) == 1, lfsr_bits(4) != 0};
            else
                b = {1'b1, lfsr_bits(4) == 0};
            frame_step(b);
            if (py == 400)
                saw_low_stop = 1;         // Lowest top row the limit allows
            if (py == 4)
                saw_top_stop = 1;
            if (py > 0)
                probe_rgb("paddle_above", 601, py - 1);
            probe_rgb("paddle_top", 601, py);
            probe_rgb("paddle_bottom", 601, py + 71);
            probe_rgb("paddle_below", 601, py + 72);
        end
        assert (saw_low_stop && saw_top_stop)
            else begin
                $display("Paddle never reached both the lower and the upper stop");
                test_errors++;
            end
        finish_test("paddle");

        // Ball flight, paddle tracks it until the bounce then moves off
        for (int i = 0; i < N_BALL; i++) begin
            if (dx > 0) begin
                if (py < by - 28)
                    b = 2'b01;
                else if (py > by - 24)
                    b = 2'b10;
                else
                    b = 2'b00;
            end else begin
                b = 2'b10;
            end
            frame_step(b);
            probe_rgb("ball_mask", bx + int'(lfsr_bits(4)), by + int'(lfsr_bits(4)));
            probe_rgb("ball_mask", bx + int'(lfsr_bits(4)), by + int'(lfsr_bits(4)));
        end
        assert (saw_bottom && saw_paddle)
            else begin
                $display("Ball never bounced off the bottom wall and the paddle");
                test_errors++;
            end
        finish_test("ball_motion");

        // Divider source, one step per 16 cycles from release
        reset_dut(1'b0);
        for (int i = 1; i <= 48; i++) begin
            @(posedge clk);
            if (i % 16 == 0)
                model_tick(2'b00);
            @(negedge clk);
            check_value("divider_x", 12'(bx), {2'b00, u_dut.ball_x});
            check_value("divider_y", 12'(by), {2'b00, u_dut.ball_y});
        end
        @(posedge clk);
        sw <= 1'b1;                       // Scan source, never matched
        for (int i = 0; i < 40; i++) begin
            @(negedge clk);
            check_value("scan_idle_x", 12'(bx), {2'b00, u_dut.ball_x});
            check_value("scan_idle_y", 12'(by), {2'b00, u_dut.ball_y});
        end
        finish_test("divider_tick");

        $display("Checks: %0d, errors: %0d", checks, total_errors);
        if (total_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== pong_animate.f ====
src/pong_pkg.sv
src/frame_tick_gen.sv
src/paddle_ctrl.sv
src/ball_ctrl.sv
src/pixel_renderer.sv
src/pong_animate.sv
tests/tb_pong_animate.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_pong_animate
FILELIST  = pong_animate.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only if the pass line shows up in the output
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
